// ==== source/heapPackage.sv ====
// Array heap shared definitions
// Opcode and error encodings used across the heap and its testbench

package heapPackage;

  // --------------------
  // Widths
  // --------------------
  localparam int OpBits    = 5;                       // Opcode field
  localparam int ErrorBits = 3;                       // Error code field

  // --------------------
  // Opcodes
  // --------------------
  // Sparse codes with unused gaps between groups
  typedef enum logic [OpBits-1:0] {
    opReset  = 5'd1,                                  // Free every array
    opWrite  = 5'd2,                                  // Store an element
    opRead   = 5'd3,                                  // Fetch an element
    opSize   = 5'd4,                                  // Current array size
    opUp     = 5'd10,                                 // Insert at index
    opDown   = 5'd11,                                 // Remove at index
    opPush   = 5'd14,                                 // Append to the end
    opPop    = 5'd15,                                 // Take from the end
    opResize = 5'd17,                                 // Load a new size
    opAlloc  = 5'd18,                                 // Hand out an array
    opFree   = 5'd19                                  // Return an array
  } heapOp;

  // --------------------
  // Error codes
  // --------------------
  typedef enum logic [ErrorBits-1:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                           // Never handed out
    errFreed        = 3'd2,                           // Handed out, then freed
    errOutOfBounds  = 3'd3,                           // Read at or past the size
    errEmpty        = 3'd4,                           // Nothing to take
    errFull         = 3'd5,                           // No room to add
    errTooLarge     = 3'd6,                           // Resize past capacity
    errOutOfMemory  = 3'd7                            // No array left to hand out
  } heapError;

endpackage

// ==== source/heapControl.sv ====
// Heap control bundle
// Decoded enables and operands from the controller, status back from storage

`timescale 1ns/10ps

interface heapControl #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
);

  // --------------------
  // Controller to storage
  // --------------------
  logic allocEnable;
  logic freeEnable;
  logic clearEnable;                                  // Heap reset opcode
  logic writeEnable;
  logic pushEnable;
  logic popEnable;
  logic upEnable;
  logic downEnable;
  logic resizeEnable;

  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    data;
  logic [indexBits:0]     newSize;                    // One bit wider to hold a full size

  // --------------------
  // Storage to controller
  // --------------------
  logic [addressBits-1:0] allocArray;                 // Number the next alloc would take
  logic                   heapFull;
  logic                   allocated;                  // Addressed array currently live
  logic                   everAllocated;              // Addressed array handed out since reset
  logic [indexBits:0]     currentSize;
  logic [dataBits-1:0]    readData;
  logic [dataBits-1:0]    popData;
  logic [dataBits-1:0]    shiftOutData;

  modport controller (
    output allocEnable, freeEnable, clearEnable, writeEnable, pushEnable,
           popEnable, upEnable, downEnable, resizeEnable,
           array, index, data, newSize,
    input  allocArray, heapFull, allocated, everAllocated, currentSize,
           readData, popData, shiftOutData
  );

  modport allocator (
    input  allocEnable, freeEnable, clearEnable, array,
    output allocArray, heapFull, allocated, everAllocated
  );

  modport sizes (
    input  allocEnable, clearEnable, writeEnable, pushEnable, popEnable,
           upEnable, downEnable, resizeEnable, array, index, newSize, allocArray,
    output currentSize
  );

  modport store (
    input  writeEnable, pushEnable, upEnable, downEnable, array, index, data,
           currentSize,
    output readData, popData, shiftOutData
  );

endinterface

// ==== source/allocationTable.sv ====
// Array allocation table
// Freed arrays are reused last in, first out before fresh numbers are issued

`timescale 1ns/10ps

module allocationTable #(
  parameter int addressBits = 2
) (
  input logic clock,
  input logic resetN,
  heapControl.allocator bus
);

  localparam int arrayCount = 1 << addressBits;

  logic [addressBits-1:0] freedStack [arrayCount];    // Freed array numbers
  logic [addressBits:0]   stackTop;                   // Entries on the stack
  logic [addressBits:0]   topSlot;
  logic [addressBits:0]   nextNew;                    // Numbers issued since reset
  logic [arrayCount-1:0]  liveFlags;                  // One per array

  assign topSlot = stackTop - 1'b1;

  // --------------------
  // Status
  // --------------------
  assign bus.allocArray    = (stackTop != '0) ? freedStack[topSlot[addressBits-1:0]]
                                              : nextNew[addressBits-1:0];
  assign bus.heapFull      = (stackTop == '0) &&
                             (nextNew == (addressBits+1)'(arrayCount));
  assign bus.allocated     = liveFlags[bus.array];
  assign bus.everAllocated = {1'b0, bus.array} < nextNew;

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop  <= '0;
      nextNew   <= '0;
      liveFlags <= '0;
    end else if (bus.clearEnable) begin
      stackTop  <= '0;
      nextNew   <= '0;
      liveFlags <= '0;
    end else if (bus.allocEnable) begin
      if (stackTop != '0) begin
        stackTop <= topSlot;                          // Reuse the last freed
      end else begin
        nextNew <= nextNew + 1'b1;
      end
      liveFlags[bus.allocArray] <= 1'b1;
    end else if (bus.freeEnable) begin
      stackTop <= stackTop + 1'b1;
      liveFlags[bus.array] <= 1'b0;                   // Cleared by array number
    end
  end

  // Double frees are rejected upstream, so the stack never overflows
  always_ff @(posedge clock) begin
    if (bus.freeEnable) begin
      freedStack[stackTop[addressBits-1:0]] <= bus.array;
    end
  end

endmodule

// ==== source/sizeTable.sv ====
// Array size table
// Holds the live length of each array, which bounds the element store moves

`timescale 1ns/10ps

module sizeTable #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3
) (
  input logic clock,
  input logic resetN,
  heapControl.sizes bus
);

  localparam int arrayCount = 1 << addressBits;

  logic [indexBits:0] sizes [arrayCount];
  logic [indexBits:0] writeEnd;                       // Size after a write at index

  assign writeEnd        = {1'b0, bus.index} + 1'b1;
  assign bus.currentSize = sizes[bus.array];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (bus.clearEnable) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (bus.allocEnable) begin
      sizes[bus.allocArray] <= '0;                    // New array starts empty
    end else if (bus.writeEnable) begin
      if (writeEnd > bus.currentSize) begin
        sizes[bus.array] <= writeEnd;                 // Write past the end grows it
      end
    end else if (bus.pushEnable || bus.upEnable) begin
      sizes[bus.array] <= bus.currentSize + 1'b1;
    end else if (bus.popEnable || bus.downEnable) begin
      sizes[bus.array] <= bus.currentSize - 1'b1;
    end else if (bus.resizeEnable) begin
      sizes[bus.array] <= bus.newSize;
    end
  end

endmodule

// ==== source/elementStore.sv ====
// Array element store
// Fixed block of elements per array, with single cycle insert and remove moves

`timescale 1ns/10ps

module elementStore #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input logic clock,
  heapControl.store bus
);

  localparam int arrayCount = 1 << addressBits;
  localparam int capacity   = 1 << indexBits;

  logic [dataBits-1:0]  memory [arrayCount][capacity];
  logic [indexBits:0]   lastSlot;                     // Index of the last element
  logic [dataBits-1:0]  addressedElement;

  assign lastSlot         = bus.currentSize - 1'b1;
  assign addressedElement = memory[bus.array][bus.index];

  // --------------------
  // Read side
  // --------------------
  assign bus.readData     = addressedElement;
  assign bus.popData      = memory[bus.array][lastSlot[indexBits-1:0]];
  assign bus.shiftOutData = addressedElement;         // Value lost by a down shift

  // --------------------
  // Write side
  // --------------------
  always_ff @(posedge clock) begin
    if (bus.writeEnable) begin
      memory[bus.array][bus.index] <= bus.data;
    end else if (bus.pushEnable) begin
      // Push is only enabled below capacity
      memory[bus.array][bus.currentSize[indexBits-1:0]] <= bus.data;
    end else if (bus.upEnable) begin
      for (int i = 1; i < capacity; i++) begin
        if (i > int'(bus.index) && i <= int'(bus.currentSize)) begin
          memory[bus.array][i] <= memory[bus.array][i-1];  // Open a gap at index
        end
      end
      memory[bus.array][bus.index] <= bus.data;
    end else if (bus.downEnable) begin
      for (int i = 1; i < capacity; i++) begin
        if (i > int'(bus.index) && i < int'(bus.currentSize)) begin
          memory[bus.array][i-1] <= memory[bus.array][i];  // Close over index
        end
      end
    end
  end

endmodule

// ==== source/heapController.sv ====
// Array heap controller
// Validates each command, raises one storage enable if it is legal, and
// registers done, result and error one clock after start

`timescale 1ns/10ps

module heapController #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   start,
  input  heapPackage::heapOp     op,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   done,
  output logic [dataBits-1:0]    result,
  output heapPackage::heapError  error,
  heapControl.controller         bus
);

  localparam int capacity = 1 << indexBits;

  heapPackage::heapError checkError;
  logic                  needsArray;                  // Command addresses a live array
  logic                  legal;
  logic [dataBits-1:0]   nextResult;

  // --------------------
  // Operands
  // --------------------
  assign bus.array   = array;
  assign bus.index   = index;
  assign bus.data    = dataIn;
  assign bus.newSize = dataIn[indexBits:0];

  // --------------------
  // Command check
  // --------------------
  // First failing check wins
  always_comb begin
    needsArray = op inside {heapPackage::opWrite, heapPackage::opRead, heapPackage::opSize,
                            heapPackage::opUp, heapPackage::opDown, heapPackage::opPush,
                            heapPackage::opPop, heapPackage::opResize, heapPackage::opFree};
    checkError = heapPackage::errNone;
    if (needsArray && !bus.everAllocated) begin
      checkError = heapPackage::errNotAllocated;
    end else if (needsArray && !bus.allocated) begin
      checkError = heapPackage::errFreed;
    end else if (op == heapPackage::opRead && {1'b0, index} >= bus.currentSize) begin
      checkError = heapPackage::errOutOfBounds;
    end else if ((op == heapPackage::opPop || op == heapPackage::opDown) &&
                 bus.currentSize == '0) begin
      checkError = heapPackage::errEmpty;
    end else if ((op == heapPackage::opPush || op == heapPackage::opUp) &&
                 bus.currentSize == (indexBits+1)'(capacity)) begin
      checkError = heapPackage::errFull;
    end else if (op == heapPackage::opResize && dataIn > dataBits'(capacity)) begin
      checkError = heapPackage::errTooLarge;
    end else if (op == heapPackage::opAlloc && bus.heapFull) begin
      checkError = heapPackage::errOutOfMemory;
    end
  end

  assign legal = start && (checkError == heapPackage::errNone);

  // --------------------
  // Enables
  // --------------------
  always_comb begin
    bus.allocEnable  = 1'b0;
    bus.freeEnable   = 1'b0;
    bus.clearEnable  = 1'b0;
    bus.writeEnable  = 1'b0;
    bus.pushEnable   = 1'b0;
    bus.popEnable    = 1'b0;
    bus.upEnable     = 1'b0;
    bus.downEnable   = 1'b0;
    bus.resizeEnable = 1'b0;
    if (legal) begin
      case (op)
        heapPackage::opReset:  bus.clearEnable  = 1'b1;
        heapPackage::opAlloc:  bus.allocEnable  = 1'b1;
        heapPackage::opFree:   bus.freeEnable   = 1'b1;
        heapPackage::opWrite:  bus.writeEnable  = 1'b1;
        heapPackage::opPush:   bus.pushEnable   = 1'b1;
        heapPackage::opPop:    bus.popEnable    = 1'b1;
        heapPackage::opUp:     bus.upEnable     = 1'b1;
        heapPackage::opDown:   bus.downEnable   = 1'b1;
        heapPackage::opResize: bus.resizeEnable = 1'b1;
        default: ;                                    // Read and size change nothing
      endcase
    end
  end

  // --------------------
  // Response
  // --------------------
  always_comb begin
    case (op)
      heapPackage::opAlloc: nextResult = dataBits'(bus.allocArray);
      heapPackage::opRead:  nextResult = bus.readData;
      heapPackage::opWrite: nextResult = dataIn;
      heapPackage::opSize:  nextResult = dataBits'(bus.currentSize);
      heapPackage::opPop:   nextResult = bus.popData;
      heapPackage::opDown:  nextResult = bus.shiftOutData;
      default:              nextResult = '0;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done   <= 1'b0;
      result <= '0;
      error  <= heapPackage::errNone;
    end else begin
      done <= start;
      if (start) begin
        result <= legal ? nextResult : '0;            // Rejected commands answer zero
        error  <= checkError;
      end
    end
  end

endmodule

// ==== source/arrayHeap.sv ====
// Array heap top level
// Fixed set of small arrays, one command per clock, answered one clock later

`timescale 1ns/10ps

module arrayHeap #(
  parameter int addressBits = 2,                      // Heap holds 2**addressBits arrays
  parameter int indexBits   = 3,                      // Each holds 2**indexBits elements
  parameter int dataBits    = 12
) (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   start,
  input  heapPackage::heapOp     op,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   done,
  output logic [dataBits-1:0]    result,
  output heapPackage::heapError  error
);

  heapControl #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) control ();

  heapController #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) controller (
    .clock (clock),
    .resetN(resetN),
    .start (start),
    .op    (op),
    .array (array),
    .index (index),
    .dataIn(dataIn),
    .done  (done),
    .result(result),
    .error (error),
    .bus   (control)
  );

  allocationTable #(.addressBits(addressBits)) allocator (
    .clock (clock),
    .resetN(resetN),
    .bus   (control)
  );

  sizeTable #(.addressBits(addressBits), .indexBits(indexBits)) sizes (
    .clock (clock),
    .resetN(resetN),
    .bus   (control)
  );

  elementStore #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) store (
    .clock(clock),
    .bus  (control)
  );

endmodule

// ==== verification/arrayHeap_assertions.sv ====
// Array heap response checker
// Bound to the heap top level, compares each done response with the command before it

`timescale 1ns/10ps

module arrayHeapAssertions #(
  parameter int addressBits = 2,
  parameter int indexBits   = 3,
  parameter int dataBits    = 12
) (
  input logic                   clock,
  input logic                   resetN,
  input logic                   start,
  input heapPackage::heapOp     op,
  input logic [addressBits-1:0] array,
  input logic [indexBits-1:0]   index,
  input logic [dataBits-1:0]    dataIn,
  input logic                   done,
  input logic [dataBits-1:0]    result,
  input heapPackage::heapError  error
);

  localparam int capacity   = 1 << indexBits;
  localparam int arrayCount = 1 << addressBits;

  int failCount = 0;

  logic                   lastStart;
  heapPackage::heapOp     lastOp;
  logic [addressBits-1:0] lastArray;
  logic [indexBits-1:0]   lastIndex;
  logic [dataBits-1:0]    lastData;
  logic                   armed;                      // Only allocs since a heap reset
  logic [addressBits:0]   runCount;                   // Allocs in that run, saturating
  logic                   sameLive;                   // Previous command kept this array live

  // --------------------
  // Command history
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      lastStart <= 1'b0;
      lastOp    <= heapPackage::opReset;
      lastArray <= '0;
      lastIndex <= '0;
      lastData  <= '0;
      armed     <= 1'b1;                              // Async reset is a fresh heap
      runCount  <= '0;
    end else begin
      lastStart <= start;
      if (start) begin
        lastOp    <= op;
        lastArray <= array;
        lastIndex <= index;
        lastData  <= dataIn;
        if (op == heapPackage::opReset) begin
          armed    <= 1'b1;
          runCount <= '0;
        end else if (op == heapPackage::opAlloc) begin
          if (runCount != (addressBits+1)'(arrayCount)) begin
            runCount <= runCount + 1'b1;
          end
        end else begin
          armed <= 1'b0;
        end
      end
    end
  end

  assign sameLive = lastStart && done && error == heapPackage::errNone &&
                    array == lastArray &&
                    lastOp inside {heapPackage::opWrite, heapPackage::opRead, heapPackage::opSize,
                                   heapPackage::opUp, heapPackage::opDown, heapPackage::opPush,
                                   heapPackage::opPop, heapPackage::opResize};

  // --------------------
  // Timing
  // --------------------
  resetState: assert property (@(posedge clock)
    !resetN |-> (!done && error == heapPackage::errNone))
    else begin
      failCount++;
      $error("FAILED at %0t: done or error set in reset", $time);
    end

  donePulse: assert property (@(posedge clock) disable iff (!resetN)
    done == $past(start))
    else begin
      failCount++;
      $error("FAILED at %0t: done does not follow start", $time);
    end

  // --------------------
  // Allocation
  // --------------------
  freshAlloc: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opAlloc && armed &&
    runCount != (addressBits+1)'(arrayCount)
    |=> error == heapPackage::errNone && result == dataBits'($past(runCount)))
    else begin
      failCount++;
      $error("FAILED at %0t: fresh alloc got %0d", $time, result);
    end

  heapExhausted: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opAlloc && armed &&
    runCount == (addressBits+1)'(arrayCount)
    |=> error == heapPackage::errOutOfMemory)
    else begin
      failCount++;
      $error("FAILED at %0t: full heap gave %s", $time, error.name());
    end

  reuseFreed: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opAlloc && lastStart && lastOp == heapPackage::opFree &&
    done && error == heapPackage::errNone
    |=> error == heapPackage::errNone && result == dataBits'($past(lastArray)))
    else begin
      failCount++;
      $error("FAILED at %0t: freed array not reused", $time);
    end

  // --------------------
  // Elements and sizes
  // --------------------
  readBack: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opRead && sameLive && lastOp == heapPackage::opWrite &&
    index == lastIndex
    |=> error == heapPackage::errNone && result == $past(lastData))
    else begin
      failCount++;
      $error("FAILED at %0t: read back %0h", $time, result);
    end

  neverAllocated: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opWrite && armed && {1'b0, array} >= runCount
    |=> error == heapPackage::errNotAllocated)
    else begin
      failCount++;
      $error("FAILED at %0t: write gave %s", $time, error.name());
    end

  writeFreed: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opWrite && lastStart && lastOp == heapPackage::opFree &&
    array == lastArray && done && error == heapPackage::errNone
    |=> error == heapPackage::errFreed)
    else begin
      failCount++;
      $error("FAILED at %0t: write gave %s", $time, error.name());
    end

  sizeBack: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opSize && sameLive && lastOp == heapPackage::opResize
    |=> error == heapPackage::errNone && result == $past(lastData))
    else begin
      failCount++;
      $error("FAILED at %0t: size read %0d", $time, result);
    end

  resizeLimit: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opResize && sameLive && dataIn > dataBits'(capacity)
    |=> error == heapPackage::errTooLarge)
    else begin
      failCount++;
      $error("FAILED at %0t: resize gave %s", $time, error.name());
    end

  readBounds: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opRead && sameLive && lastOp == heapPackage::opResize &&
    dataBits'(index) >= lastData
    |=> error == heapPackage::errOutOfBounds)
    else begin
      failCount++;
      $error("FAILED at %0t: read gave %s", $time, error.name());
    end

  // --------------------
  // Stack and shifts
  // --------------------
  popBack: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opPop && sameLive && lastOp == heapPackage::opPush
    |=> error == heapPackage::errNone && result == $past(lastData))
    else begin
      failCount++;
      $error("FAILED at %0t: pop returned %0h", $time, result);
    end

  popEmpty: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opPop && sameLive && lastOp == heapPackage::opResize &&
    lastData == '0
    |=> error == heapPackage::errEmpty)
    else begin
      failCount++;
      $error("FAILED at %0t: pop gave %s", $time, error.name());
    end

  pushFull: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opPush && sameLive && lastOp == heapPackage::opResize &&
    lastData == dataBits'(capacity)
    |=> error == heapPackage::errFull)
    else begin
      failCount++;
      $error("FAILED at %0t: push gave %s", $time, error.name());
    end

  shiftBack: assert property (@(posedge clock) disable iff (!resetN)
    start && op == heapPackage::opDown && sameLive && lastOp == heapPackage::opUp &&
    index == lastIndex
    |=> error == heapPackage::errNone && result == $past(lastData))
    else begin
      failCount++;
      $error("FAILED at %0t: down returned %0h", $time, result);
    end

endmodule

bind arrayHeap arrayHeapAssertions #(
  .addressBits(addressBits),
  .indexBits  (indexBits),
  .dataBits   (dataBits)
) checks (
  .clock (clock),
  .resetN(resetN),
  .start (start),
  .op    (op),
  .array (array),
  .index (index),
  .dataIn(dataIn),
  .done  (done),
  .result(result),
  .error (error)
);

// ==== verification/arrayHeapTb.sv ====
// Array heap testbench
// Issues command pairs on back to back cycles so the bound checker sees each behavior

`timescale 1ns/10ps

module arrayHeapTb;

  localparam int addressBits = 2;
  localparam int indexBits   = 3;
  localparam int dataBits    = 12;
  localparam int capacity    = 1 << indexBits;
  localparam int arrayCount  = 1 << addressBits;
  localparam int doneTimeout = 20;                    // Cycles to wait for done
  localparam int driveDelay  = 5;                     // After the rising edge

  logic                   clock;
  logic                   resetN;
  logic                   start;
  heapPackage::heapOp     op;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    dataIn;
  logic                   done;
  logic [dataBits-1:0]    result;
  heapPackage::heapError  error;

  int timeoutCount;
  int failures;

  arrayHeap #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) arrayHeap_inst (
    .clock (clock),
    .resetN(resetN),
    .start (start),
    .op    (op),
    .array (array),
    .index (index),
    .dataIn(dataIn),
    .done  (done),
    .result(result),
    .error (error)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;                          // 100 ns period

  // --------------------
  // Command tasks
  // --------------------
  task automatic issueCommand(input heapPackage::heapOp code, input int arrayNumber,
                              input int position, input int value);
    @(posedge clock);
    #driveDelay;
    start  = 1'b1;
    op     = code;
    array  = addressBits'(arrayNumber);
    index  = indexBits'(position);
    dataIn = dataBits'(value);
  endtask

  task automatic waitForDone;
    int cycles;
    cycles = 0;
    while (!done && cycles < doneTimeout) begin
      @(posedge clock);
      #driveDelay;
      cycles++;
    end
    if (!done) begin
      timeoutCount++;
      $display("Timeout: no done pulse within %0d cycles at %0t", doneTimeout, $time);
    end
  endtask

  // Drops start and waits for the last command's response
  task automatic endBurst;
    @(posedge clock);
    #driveDelay;
    start = 1'b0;
    waitForDone();
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int position;
    int value;
    void'($urandom(32'hfe31e933));
    resetN       = 1'b0;
    start        = 1'b0;
    op           = heapPackage::opReset;
    array        = '0;
    index        = '0;
    dataIn       = '0;
    timeoutCount = 0;
    repeat (3) @(posedge clock);
    #driveDelay resetN = 1'b1;

    issueCommand(heapPackage::opReset, 0, 0, 0);      // Fresh run, then one alloc too many
    for (int i = 0; i <= arrayCount; i++) begin
      issueCommand(heapPackage::opAlloc, 0, 0, 0);
    end
    endBurst();
    issueCommand(heapPackage::opFree, 2, 0, 0);
    issueCommand(heapPackage::opAlloc, 0, 0, 0);
    endBurst();

    for (int i = 0; i < 4; i++) begin
      position = int'($urandom_range(capacity - 1));
      value    = int'($urandom_range((1 << dataBits) - 1));
      issueCommand(heapPackage::opWrite, 1, position, value);
      issueCommand(heapPackage::opRead, 1, position, 0);
    end
    endBurst();
    issueCommand(heapPackage::opFree, 3, 0, 0);
    issueCommand(heapPackage::opWrite, 3, 0, int'($urandom_range(255)));
    issueCommand(heapPackage::opReset, 0, 0, 0);      // Only array 0 handed out below
    issueCommand(heapPackage::opAlloc, 0, 0, 0);
    issueCommand(heapPackage::opWrite, 2, 0, int'($urandom_range(255)));
    endBurst();

    issueCommand(heapPackage::opResize, 0, 0, 5);
    issueCommand(heapPackage::opSize, 0, 0, 0);
    issueCommand(heapPackage::opResize, 0, 0, capacity + 1 + int'($urandom_range(100)));
    issueCommand(heapPackage::opResize, 0, 0, 2);
    issueCommand(heapPackage::opRead, 0, 2 + int'($urandom_range(capacity - 3)), 0);
    for (int i = 0; i < 4; i++) begin
      issueCommand(heapPackage::opPush, 0, 0, int'($urandom_range((1 << dataBits) - 1)));
      issueCommand(heapPackage::opPop, 0, 0, 0);
    end
    issueCommand(heapPackage::opResize, 0, 0, 0);
    issueCommand(heapPackage::opPop, 0, 0, 0);
    issueCommand(heapPackage::opResize, 0, 0, capacity);
    issueCommand(heapPackage::opPush, 0, 0, int'($urandom_range(255)));
    issueCommand(heapPackage::opResize, 0, 0, 4);
    issueCommand(heapPackage::opUp, 0, 1, int'($urandom_range((1 << dataBits) - 1)));
    issueCommand(heapPackage::opDown, 0, 1, 0);
    endBurst();

    repeat (2) @(posedge clock);                      // Let the last checks settle
    failures = arrayHeap_inst.checks.failCount;
    $display("Run complete: %0d assertion failures, %0d timeouts", failures, timeoutCount);
    if (failures == 0 && timeoutCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== arrayHeap.f ====
source/heapPackage.sv
source/heapControl.sv
source/allocationTable.sv
source/sizeTable.sv
source/elementStore.sv
source/heapController.sv
source/arrayHeap.sv
verification/arrayHeap_assertions.sv
verification/arrayHeapTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the array heap testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module arrayHeapTb -f arrayHeap.f \
  && ./obj_dir/VarrayHeapTb +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -qF "*** PASSED ***" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
